// ==== hw/rhPkg.sv ====
//////////////////////////////////////////////////////////////////////
// Address and count half of an RH11 only, 16-bit little-endian bus
// No drive side, no interrupts, no error bits
//////////////////////////////////////////////////////////////////////

package rhPkg;

   // Register byte offsets on the host bus
   localparam logic [2:0] cs1Offset = 3'd0;
   localparam logic [2:0] wcOffset  = 3'd2;
   localparam logic [2:0] baOffset  = 3'd4;

   // Bus widths
   localparam int addrWidth = 18;
   localparam int dataWidth = 16;

   //////////////////////////////////////////////////////////////////////
   // Host bus access
   //////////////////////////////////////////////////////////////////////

   typedef struct packed {
      logic                 wr;
      logic                 rd;
      logic [2:0]           offset;
      logic                 hiByte;
      logic                 loByte;
      logic [dataWidth-1:0] data;
   } busReq_t;

   //////////////////////////////////////////////////////////////////////
   // Data word views
   //////////////////////////////////////////////////////////////////////

   // RHCS1 field layout, bit 15 first
   typedef struct packed {
      logic [5:0] unused;
      logic [1:0] bae;
      logic       rdy;
      // Interrupt enable, kept but never acted on
      logic       ie;
      logic [4:0] func;
      logic       go;
   } cs1Fields_t;

   // Plain byte lanes
   typedef struct packed {
      logic [7:0] hi;
      logic [7:0] lo;
   } bytePair_t;

   // Same 16 bits seen as CS1 fields or as two bytes
   typedef union packed {
      cs1Fields_t cs1;
      bytePair_t  bytes;
   } rhWord_u;

   // Decoded write, one strobe per register
   typedef struct packed {
      logic    cs1Wr;
      logic    wcWr;
      logic    baWr;
      logic    hiByte;
      logic    loByte;
      rhWord_u data;
   } regWrite_t;

endpackage

// ==== hw/rhRegDecode.sv ====
//////////////////////////////////////////////////////////////////////
// Read data is combinational and is zero without a read strobe
// Unknown offsets write nothing and read zero
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rhRegDecode
(
   input  logic                          clk,
   input  logic                          rst,
   input  rhPkg::busReq_t                bus,
   input  rhPkg::rhWord_u                cs1Value,
   input  rhPkg::rhWord_u                wcValue,
   input  rhPkg::rhWord_u                baLow,
   output rhPkg::regWrite_t              regWr,
   output logic [rhPkg::dataWidth-1:0]   rdData
);

   //////////////////////////////////////////////////////////////////////
   // Write strobes
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      // At most one strobe, picked by offset
      regWr.cs1Wr  = bus.wr && (bus.offset == rhPkg::cs1Offset);
      regWr.wcWr   = bus.wr && (bus.offset == rhPkg::wcOffset);
      regWr.baWr   = bus.wr && (bus.offset == rhPkg::baOffset);
      // Lanes and data shared by all three registers
      regWr.hiByte = bus.hiByte;
      regWr.loByte = bus.loByte;
      regWr.data   = bus.data;
   end

   //////////////////////////////////////////////////////////////////////
   // Read mux
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      rdData = '0;
      if (bus.rd)
      begin
         case (bus.offset)
            rhPkg::cs1Offset: rdData = cs1Value;
            rhPkg::wcOffset:  rdData = wcValue;
            rhPkg::baOffset:  rdData = baLow;
            default:          rdData = '0;
         endcase
      end
   end

   // Host never reads and writes in one cycle
   busExclusive: assert property (@(posedge clk) disable iff (rst) !(bus.wr && bus.rd))
      else $error("bus wr and rd both high");

endmodule

// ==== hw/rhCs1.sv ====
//////////////////////////////////////////////////////////////////////
// Function and ie change only while ready, GO always reads as 0
// BAE bits are stored in the BA register, shown here for reads
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rhCs1
(
   input  logic              clk,
   input  logic              rst,
   input  logic              clr,
   input  rhPkg::regWrite_t  regWr,
   input  logic              xferDone,
   input  logic [1:0]        bae,
   output rhPkg::rhWord_u    cs1Value,
   output logic [4:0]        func,
   output logic              rdy,
   output logic              goStart
);

   // Interrupt enable bit
   logic ie;
   // Low byte write accepted
   logic loWrite;

   // Low byte holds go, func and ie
   assign loWrite = regWr.cs1Wr && regWr.loByte && rdy;

   // Start pulse, same cycle as the write
   assign goStart = loWrite && regWr.data.cs1.go;

   //////////////////////////////////////////////////////////////////////
   // Function and interrupt enable
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         func <= '0;
         ie   <= 1'b0;
      end
      else if (clr)
         func <= '0;
      else if (loWrite)
      begin
         func <= regWr.data.cs1.func;
         ie   <= regWr.data.cs1.ie;
      end
   end

   // Ready flag, clear wins over start, start over done
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         rdy <= 1'b1;
      else if (clr)
         rdy <= 1'b1;
      else if (goStart)
         rdy <= 1'b0;
      else if (xferDone)
         rdy <= 1'b1;
   end

   //////////////////////////////////////////////////////////////////////
   // Read view
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      cs1Value.cs1.unused = '0;
      cs1Value.cs1.bae    = bae;
      cs1Value.cs1.rdy    = rdy;
      cs1Value.cs1.ie     = ie;
      cs1Value.cs1.func   = func;
      cs1Value.cs1.go     = 1'b0;
   end

   // A start needs ready and drops it at the next edge unless cleared
   goNeedsRdy: assert property (@(posedge clk) disable iff (rst)
                               (goStart && !clr) |-> rdy ##1 !rdy)
      else $error("goStart without ready, or ready not dropped");

endmodule

// ==== hw/rhWc.sv ====
//////////////////////////////////////////////////////////////////////
// Count runs up to zero, a written byte beats the increment
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rhWc
(
   input  logic              clk,
   input  logic              rst,
   input  logic              clr,
   input  rhPkg::regWrite_t  regWr,
   input  logic              inc,
   output rhPkg::rhWord_u    wcValue,
   output logic              wcLast
);

   // Stored count and next value
   logic [15:0] count;
   logic [15:0] countNext;

   // Increment first, then overlay the written lanes
   always_comb
   begin
      countNext = inc ? count + 16'd1 : count;
      if (regWr.wcWr && regWr.hiByte)
         countNext[15:8] = regWr.data.bytes.hi;
      if (regWr.wcWr && regWr.loByte)
         countNext[7:0] = regWr.data.bytes.lo;
   end

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         count <= '0;
      else if (clr)
         count <= '0;
      else
         count <= countNext;
   end

   // All ones means one word left
   assign wcLast = &count;

   // Read view
   assign wcValue = count;

endmodule

// ==== hw/rhBa.sv ====
//////////////////////////////////////////////////////////////////////
// Extension bits load through CS1 only while ready
// Any BA write blocks the increment for that cycle
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rhBa
(
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          clr,
   input  rhPkg::regWrite_t              regWr,
   input  logic                          rdy,
   input  logic                          inc,
   output logic [rhPkg::addrWidth-1:0]   rhBa
);

   // CS1 high byte carries the extension field
   logic extLoad;

   assign extLoad = regWr.cs1Wr && regWr.hiByte && rdy;

   //////////////////////////////////////////////////////////////////////
   // Address register
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         rhBa <= '0;
      else if (clr)
         rhBa <= '0;
      else
      begin
         if (extLoad)
            rhBa[17:16] <= regWr.data.cs1.bae;
         if (regWr.baWr)
         begin
            if (regWr.hiByte)
               rhBa[15:8] <= regWr.data.bytes.hi;
            if (regWr.loByte)
               rhBa[7:0] <= regWr.data.bytes.lo;
         end
         // Word step, carry runs into the extension bits
         else if (inc)
            rhBa <= rhBa + 18'd2;
      end
   end

endmodule

// ==== hw/rhDmaSeq.sv ====
//////////////////////////////////////////////////////////////////////
// Two states only, the run length comes from the word count
// dmaAck is honoured only while dmaReq is high
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rhDmaSeq
(
   input  logic clk,
   input  logic rst,
   input  logic clr,
   input  logic goStart,
   input  logic wcLast,
   input  logic dmaAck,
   output logic dmaReq,
   output logic xferWord,
   output logic xferDone
);

   // Busy state, idle when low
   logic busy;

   //////////////////////////////////////////////////////////////////////
   // State
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         busy <= 1'b0;
      else if (clr)
         busy <= 1'b0;
      else if (goStart)
         busy <= 1'b1;
      else if (xferDone)
         busy <= 1'b0;
   end

   // Request held for the whole run
   assign dmaReq = busy;

   // One word per acknowledge
   assign xferWord = busy && dmaAck;

   // Last word ends the run
   assign xferDone = xferWord && wcLast;

   //////////////////////////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////////////////////////

   // Memory side must not acknowledge without a request
   ackInReq: assert property (@(posedge clk) disable iff (rst) dmaAck |-> dmaReq)
      else $error("dmaAck without dmaReq");

   // Done comes with the last word and the request drops after it
   doneEndsRun: assert property (@(posedge clk) disable iff (rst)
                                xferDone |-> xferWord ##1 !dmaReq)
      else $error("xferDone without word, or dmaReq still high");

endmodule

// ==== hw/rh11Dma.sv ====
//////////////////////////////////////////////////////////////////////
// Host bus in, memory request out, one word per acknowledge
// rdData is valid in the cycle of the read strobe
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rh11Dma
(
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          clr,
   input  rhPkg::busReq_t                bus,
   output logic [rhPkg::dataWidth-1:0]   rdData,
   output logic                          dmaReq,
   input  logic                          dmaAck,
   output logic [rhPkg::addrWidth-1:0]   dmaAddr,
   output logic [4:0]                    dmaFunc
);

   // Register side
   rhPkg::regWrite_t regWr;
   rhPkg::rhWord_u   cs1Value;
   rhPkg::rhWord_u   wcValue;
   rhPkg::rhWord_u   baLow;
   logic [1:0]       bae;
   logic             rdy;
   logic             goStart;
   logic             wcLast;

   // Sequencer side
   logic xferWord;
   logic xferDone;

   // BA split for the read views
   assign baLow = dmaAddr[15:0];
   assign bae   = dmaAddr[17:16];

   rhRegDecode uDecode (
      .clk(clk), .rst(rst), .bus(bus), .cs1Value(cs1Value), .wcValue(wcValue),
      .baLow(baLow), .regWr(regWr), .rdData(rdData)
   );

   rhCs1 uCs1 (
      .clk(clk), .rst(rst), .clr(clr), .regWr(regWr), .xferDone(xferDone),
      .bae(bae), .cs1Value(cs1Value), .func(dmaFunc), .rdy(rdy), .goStart(goStart)
   );

   rhWc uWc (
      .clk(clk), .rst(rst), .clr(clr), .regWr(regWr), .inc(xferWord),
      .wcValue(wcValue), .wcLast(wcLast)
   );

   // BA is the memory address directly
   rhBa uBa (
      .clk(clk), .rst(rst), .clr(clr), .regWr(regWr), .rdy(rdy), .inc(xferWord),
      .rhBa(dmaAddr)
   );

   rhDmaSeq uSeq (
      .clk(clk), .rst(rst), .clr(clr), .goStart(goStart), .wcLast(wcLast),
      .dmaAck(dmaAck), .dmaReq(dmaReq), .xferWord(xferWord), .xferDone(xferDone)
   );

endmodule

// ==== tb/rh11DmaTb.sv ====
//////////////////////////////////////////////////////////////////////
// Acks are driven only while dmaReq is high, one bus access per cycle
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rh11DmaTb;

   // 12 runs of up to 8 words with 4 idle cycles each plus setup
   localparam int runCount   = 12;
   localparam int cycleLimit = 4000;

   logic clk;
   logic rst;
   logic clr;
   rhPkg::busReq_t bus;
   logic [15:0] rdData;
   logic dmaReq;
   logic dmaAck;
   logic [17:0] dmaAddr;
   logic [4:0] dmaFunc;

   // Reference model state
   logic [17:0] mBa;
   logic [15:0] mWc;
   logic mRdy;
   logic mBusy;
   logic mIe;
   logic [4:0] mFunc;
   logic cs1Lo;
   logic cs1Hi;
   logic goNow;
   logic word;
   logic [15:0] expRead;

   // Run bookkeeping
   logic trackRun;
   logic [17:0] runStart;
   logic [16:0] ackIndex;
   logic [16:0] expAcks;
   logic [4:0] runFunc;
   logic [17:0] ackAddr;
   logic baFull;
   logic [15:0] baWritten;
   logic [31:0] seed = 32'h604d;
   int errors = 0;
   int cycles = 0;

   rh11Dma dut (
      .clk(clk), .rst(rst), .clr(clr), .bus(bus), .rdData(rdData), .dmaReq(dmaReq),
      .dmaAck(dmaAck), .dmaAddr(dmaAddr), .dmaFunc(dmaFunc)
   );

   initial clk = 1'b0;
   always #2 clk = ~clk;

   //////////////////////////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////////////////////////

   assign cs1Lo   = bus.wr && bus.offset == rhPkg::cs1Offset && bus.loByte;
   assign cs1Hi   = bus.wr && bus.offset == rhPkg::cs1Offset && bus.hiByte;
   assign goNow   = cs1Lo && mRdy && bus.data[0];
   assign word    = mBusy && dmaAck;
   assign baFull  = bus.wr && bus.offset == rhPkg::baOffset && bus.hiByte && bus.loByte;
   // Word n of a run sits at start plus 2n
   assign ackAddr = runStart + {ackIndex, 1'b0};

   always @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         mBa   <= '0;
         mWc   <= '0;
         mRdy  <= 1'b1;
         mBusy <= 1'b0;
         mIe   <= 1'b0;
         mFunc <= '0;
      end
      else if (clr)
      begin
         mBa   <= '0;
         mWc   <= '0;
         mRdy  <= 1'b1;
         mBusy <= 1'b0;
         mFunc <= '0;
      end
      else
      begin : modelStep
         logic [17:0] ba;
         logic [15:0] wc;
         // Count steps up, written lanes override
         wc = word ? mWc + 16'd1 : mWc;
         if (bus.wr && bus.offset == rhPkg::wcOffset && bus.hiByte)
            wc[15:8] = bus.data[15:8];
         if (bus.wr && bus.offset == rhPkg::wcOffset && bus.loByte)
            wc[7:0] = bus.data[7:0];
         ba = mBa;
         if (cs1Hi && mRdy)
            ba[17:16] = bus.data[9:8];
         // Any BA write suppresses the step by two
         if (bus.wr && bus.offset == rhPkg::baOffset)
         begin
            if (bus.hiByte)
               ba[15:8] = bus.data[15:8];
            if (bus.loByte)
               ba[7:0] = bus.data[7:0];
         end
         else if (word)
            ba = mBa + 18'd2;
         if (cs1Lo && mRdy)
         begin
            mFunc <= bus.data[5:1];
            mIe   <= bus.data[6];
         end
         // Last word is the one taken at count all ones
         if (goNow)
         begin
            mRdy  <= 1'b0;
            mBusy <= 1'b1;
         end
         else if (word && mWc == 16'hffff)
         begin
            mRdy  <= 1'b1;
            mBusy <= 1'b0;
         end
         mWc <= wc;
         mBa <= ba;
      end
   end

   // Expected read data per offset
   always_comb
   begin
      case (bus.offset)
         rhPkg::cs1Offset: expRead = {6'd0, mBa[17:16], mRdy, mIe, mFunc, 1'b0};
         rhPkg::wcOffset:  expRead = mWc;
         rhPkg::baOffset:  expRead = mBa[15:0];
         default:          expRead = '0;
      endcase
   end

   // Ack index restarts with each GO
   always @(posedge clk)
   begin
      if (goNow)
         ackIndex <= '0;
      else if (dmaAck && trackRun)
         ackIndex <= ackIndex + 17'd1;
      if (baFull)
         baWritten <= bus.data;
   end

   //////////////////////////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////////////////////////

   readCheck: assert property (@(posedge clk) disable iff (rst) bus.rd |-> rdData == expRead)
      else
      begin
         errors = errors + 1;
         $display("error rdData got %h expected %h", $sampled(rdData), $sampled(expRead));
      end

   addrCheck: assert property (@(posedge clk) disable iff (rst) dmaAddr == mBa)
      else
      begin
         errors = errors + 1;
         $display("error dmaAddr got %h expected %h", $sampled(dmaAddr), $sampled(mBa));
      end

   reqCheck: assert property (@(posedge clk) disable iff (rst) dmaReq == mBusy)
      else
      begin
         errors = errors + 1;
         $display("error dmaReq got %h expected %h", $sampled(dmaReq), $sampled(mBusy));
      end

   funcCheck: assert property (@(posedge clk) disable iff (rst) dmaFunc == mFunc)
      else
      begin
         errors = errors + 1;
         $display("error dmaFunc got %h expected %h", $sampled(dmaFunc), $sampled(mFunc));
      end

   ackAddrCheck: assert property (@(posedge clk) disable iff (rst)
                                  (trackRun && dmaAck) |-> dmaAddr == ackAddr)
      else
      begin
         errors = errors + 1;
         $display("error dmaAddr got %h expected %h", $sampled(dmaAddr), $sampled(ackAddr));
      end

   // Word count and function seen when the request drops
   runEndCheck: assert property (@(posedge clk) disable iff (rst)
                                 (trackRun && $fell(dmaReq)) |->
                                 (ackIndex == expAcks && dmaFunc == runFunc))
      else
      begin
         errors = errors + 1;
         $display("error ackIndex got %h expected %h, dmaFunc got %h expected %h",
                  $sampled(ackIndex), $sampled(expAcks), $sampled(dmaFunc),
                  $sampled(runFunc));
      end

   baWriteWins: assert property (@(posedge clk) disable iff (rst)
                                 baFull |=> dmaAddr[15:0] == baWritten)
      else
      begin
         errors = errors + 1;
         $display("error dmaAddr got %h expected %h", $sampled(dmaAddr[15:0]),
                  $sampled(baWritten));
      end

   clrEndsRun: assert property (@(posedge clk) disable iff (rst) clr |=> !dmaReq)
      else
      begin
         errors = errors + 1;
         $display("dmaReq still high one cycle after controller clear");
      end

   // Run limit
   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= cycleLimit)
      begin
         $display("timeout, the tests did not end within %0d cycles", cycleLimit);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Stimulus helpers
   //////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic nextRandom(output logic [31:0] r);
      seed = xorshift(seed);
      r = seed;
   endtask

   // Inputs change 1 ns after the rising edge
   task automatic nextCycle();
      @(posedge clk);
      #1;
   endtask

   task automatic writeReg(input logic [2:0] off, input logic hi, input logic lo,
                           input logic [15:0] d);
      bus.wr     = 1'b1;
      bus.rd     = 1'b0;
      bus.offset = off;
      bus.hiByte = hi;
      bus.loByte = lo;
      bus.data   = d;
      nextCycle();
      bus = '0;
   endtask

   task automatic readReg(input logic [2:0] off);
      bus.rd     = 1'b1;
      bus.offset = off;
      nextCycle();
      bus = '0;
   endtask

   // BA, extension, negated count, then GO with the function
   task automatic startRun(input logic [17:0] start, input logic [15:0] words,
                           input logic [4:0] func);
      writeReg(rhPkg::baOffset, 1'b1, 1'b1, start[15:0]);
      writeReg(rhPkg::cs1Offset, 1'b1, 1'b0, {6'd0, start[17:16], 8'h00});
      writeReg(rhPkg::wcOffset, 1'b1, 1'b1, ~words + 16'd1);
      runStart = start;
      expAcks  = {1'b0, words};
      runFunc  = func;
      writeReg(rhPkg::cs1Offset, 1'b0, 1'b1, {8'h00, 2'b00, func, 1'b1});
   endtask

   // Random gap of 0 to 4 cycles before each ack
   task automatic ackRun(input int maxWords);
      logic [31:0] r;
      int given;
      given = 0;
      while (dmaReq && given < maxWords)
      begin
         nextRandom(r);
         repeat (r % 5) nextCycle();
         dmaAck = 1'b1;
         nextCycle();
         dmaAck = 1'b0;
         given++;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////////////////////////

   initial
   begin
      logic [31:0] r;
      logic [31:0] r2;
      rst      = 1'b1;
      clr      = 1'b0;
      bus      = '0;
      dmaAck   = 1'b0;
      trackRun = 1'b0;
      runStart = '0;
      expAcks  = '0;
      runFunc  = '0;
      repeat (4) @(posedge clk);
      #1;
      rst = 1'b0;
      // Reset values and a read of an unknown offset
      readReg(rhPkg::cs1Offset);
      readReg(rhPkg::wcOffset);
      readReg(rhPkg::baOffset);
      readReg(3'd6);
      // Single and double lane writes
      for (int i = 0; i < 8; i++)
      begin
         nextRandom(r);
         nextRandom(r2);
         writeReg(r[0] ? rhPkg::wcOffset : rhPkg::baOffset, r[1], r[2], r2[15:0]);
         readReg(rhPkg::wcOffset);
         readReg(rhPkg::baOffset);
      end
      // CS1 writes while ready load the extension bits, func and ie without GO
      for (int i = 0; i < 4; i++)
      begin
         nextRandom(r);
         writeReg(rhPkg::cs1Offset, 1'b1, 1'b1, {r[15:1], 1'b0});
         readReg(rhPkg::cs1Offset);
      end
      // Random runs
      trackRun = 1'b1;
      for (int i = 0; i < runCount; i++)
      begin
         nextRandom(r);
         nextRandom(r2);
         startRun(r[17:0], {13'd0, r2[2:0]} + 16'd1, r2[8:4]);
         ackRun(1000);
         readReg(rhPkg::wcOffset);
         readReg(rhPkg::cs1Offset);
         readReg(rhPkg::baOffset);
      end
      trackRun = 1'b0;
      // Extension write dropped mid run, then BA write against an ack
      nextRandom(r);
      startRun(r[17:0], 16'd4, 5'h0b);
      writeReg(rhPkg::cs1Offset, 1'b1, 1'b0, {6'd0, ~r[17:16], 8'h00});
      readReg(rhPkg::cs1Offset);
      ackRun(1);
      nextRandom(r2);
      bus.wr     = 1'b1;
      bus.offset = rhPkg::baOffset;
      bus.hiByte = 1'b1;
      bus.loByte = 1'b1;
      bus.data   = r2[15:0];
      dmaAck     = 1'b1;
      nextCycle();
      bus    = '0;
      dmaAck = 1'b0;
      ackRun(1000);
      readReg(rhPkg::baOffset);
      // Controller clear partway through a run
      nextRandom(r);
      startRun(r[17:0], 16'd6, 5'h15);
      ackRun(2);
      clr = 1'b1;
      nextCycle();
      clr = 1'b0;
      readReg(rhPkg::baOffset);
      readReg(rhPkg::wcOffset);
      readReg(rhPkg::cs1Offset);
      nextCycle();
      $display("tests done after %0d cycles with %0d errors", cycles, errors);
      if (errors == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

// ==== verilog.f ====
hw/rhPkg.sv
hw/rhRegDecode.sv
hw/rhCs1.sv
hw/rhWc.sv
hw/rhBa.sv
hw/rhDmaSeq.sv
hw/rh11Dma.sv
tb/rh11DmaTb.sv

// ==== run.sh ====
#!/bin/bash
# Build the RH11 DMA model with Verilator, run the testbench and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module rh11DmaTb -f verilog.f -o rhSim \
   && ./obj_dir/rhSim > sim.log 2>&1 \
   || echo "TESTBENCH FAILED" >> sim.log

cat sim.log

grep -q "TESTBENCH FAILED" sim.log && exit 1 || exit 0
